// File: files.f
verilog/tage_pkg.sv
verilog/tage_bank_if.sv
verilog/tage_history.sv
verilog/tage_hash.sv
verilog/tage_bank.sv
verilog/tage_base.sv
verilog/tage_select.sv
verilog/tage_top.sv
tests/tage_chk.sv
tests/tage_tb.sv

// File: run.sh
#!/bin/sh
# build and run the TAGE testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tage_tb -f files.f -o tage_sim
./obj_dir/tage_sim > sim.log 2>&1
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
	exit 1
fi
exit 0

// File: tests/tage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tage_tb;
	import tage_pkg::*;

	localparam int ROWS_MAX = 160;
	localparam logic KIND_LOOKUP = 1'b0;
	localparam logic KIND_UPDATE = 1'b1;
	localparam int PC_A = 0;
	localparam int PC_B = 1;
	localparam int PC_C = 2;

	logic clk;
	logic rst_n;
	logic lookup;
	pc_t lookup_pc;
	logic update;
	pc_t upd_pc;
	logic upd_taken;
	logic upd_hit;
	bank_id_t upd_provider;
	ctr_t upd_ctr;
	u_t upd_u;
	bank_mask_t upd_u_mask;
	logic upd_pred_taken;
	base_ctr_t upd_base_ctr;
	logic pred_valid;
	logic pred_taken;
	logic pred_hit;
	bank_id_t pred_provider;
	ctr_t pred_ctr;
	u_t pred_u;
	bank_mask_t pred_u_mask;
	base_ctr_t pred_base_ctr;

	// stimulus table
	logic row_kind [ROWS_MAX];
	int row_pc [ROWS_MAX];
	logic row_outcome [ROWS_MAX];
	logic exp_taken [ROWS_MAX];
	logic exp_hit [ROWS_MAX];
	bank_id_t exp_provider [ROWS_MAX];
	ctr_t exp_ctr [ROWS_MAX];
	base_ctr_t exp_base [ROWS_MAX];
	string row_name [ROWS_MAX];
	int n_rows;

	pc_t pcs [3];
	integer seed;
	int errors;
	int cycles;
	int timeout_limit;

	// metadata of the latest prediction that each update returns
	logic meta_taken;
	logic meta_hit;
	bank_id_t meta_provider;
	ctr_t meta_ctr;
	u_t meta_u;
	bank_mask_t meta_u_mask;
	base_ctr_t meta_base_ctr;

	tage_top DUT (.*);

	bind tage_top tage_chk u_chk (
		.clk           (clk),
		.rst_n         (rst_n),
		.lookup        (lookup),
		.pred_valid    (pred_valid),
		.pred_hit      (pred_hit),
		.pred_provider (pred_provider),
		.pred_ctr      (pred_ctr),
		.pred_u        (pred_u),
		.pred_u_mask   (pred_u_mask)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > timeout_limit) begin
			$display("timeout: no result after %0d cycles", timeout_limit);
			$display("=== FAIL ===");
			$finish;
		end
	end

	task automatic lookup_row(input int pc_sel, input logic taken, input logic hit,
			input bank_id_t provider, input ctr_t ctr, input base_ctr_t base,
			input string name);
		row_kind[n_rows] = KIND_LOOKUP;
		row_pc[n_rows] = pc_sel;
		row_outcome[n_rows] = 1'b0;
		exp_taken[n_rows] = taken;
		exp_hit[n_rows] = hit;
		exp_provider[n_rows] = provider;
		exp_ctr[n_rows] = ctr;
		exp_base[n_rows] = base;
		row_name[n_rows] = name;
		n_rows++;
	endtask

	task automatic update_row(input int pc_sel, input logic outcome);
		row_kind[n_rows] = KIND_UPDATE;
		row_pc[n_rows] = pc_sel;
		row_outcome[n_rows] = outcome;
		row_name[n_rows] = "update";
		n_rows++;
	endtask

	// not-taken updates of pc c shift the whole history back to zero
	task automatic clear_history(input base_ctr_t base_c);
		lookup_row(PC_C, 1'b0, 1'b0, 2'd0, 3'd0, base_c, "history clear lookup");
		repeat (GHIST_W) update_row(PC_C, 1'b0);
	endtask

	// distinct tag top bits and distinct bank 0 index at zero history
	task automatic pick_pcs();
		pc_t pc;
		int n;
		logic ok;
		n = 0;
		while (n < 3) begin
			pc = $random(seed);
			pc[1:0] = 2'b00;
			ok = 1'b1;
			for (int i = 0; i < n; i++) begin
				if (pc[9:7] == pcs[i][9:7]) ok = 1'b0;
				if ((pc[7:2] ^ pc[13:8]) == (pcs[i][7:2] ^ pcs[i][13:8])) ok = 1'b0;
			end
			if (ok) begin
				pcs[n] = pc;
				n++;
			end
		end
	endtask

	task automatic build_table();
		lookup_row(PC_A, 1'b0, 1'b0, 2'd0, 3'd0, 2'd1, "reset lookup a");
		lookup_row(PC_B, 1'b0, 1'b0, 2'd0, 3'd0, 2'd1, "reset lookup b");
		lookup_row(PC_C, 1'b0, 1'b0, 2'd0, 3'd0, 2'd1, "reset lookup c");
		// base counter 1 to 2 to 3 while the history moves on
		lookup_row(PC_A, 1'b0, 1'b0, 2'd0, 3'd0, 2'd1, "a before training");
		update_row(PC_A, 1'b1);
		lookup_row(PC_A, 1'b1, 1'b0, 2'd0, 3'd0, 2'd2, "a after one taken");
		update_row(PC_A, 1'b1);
		lookup_row(PC_A, 1'b1, 1'b0, 2'd0, 3'd0, 2'd3, "a after two taken");
		// miss and mispredict under zero history allocates bank 0
		clear_history(2'd1);
		lookup_row(PC_B, 1'b0, 1'b0, 2'd0, 3'd0, 2'd1, "b before allocation");
		update_row(PC_B, 1'b1);
		clear_history(2'd0);
		lookup_row(PC_B, 1'b1, 1'b1, 2'd0, 3'd4, 2'd2, "b hits bank 0");
		// wrong bank 0 provider allocates bank 1 at counter 3
		update_row(PC_B, 1'b0);
		lookup_row(PC_B, 1'b0, 1'b1, 2'd1, 3'd3, 2'd1, "b provider bank 1");
		// bank 1 counter 3 to 4 and the miss also allocates bank 2 at 4
		update_row(PC_B, 1'b1);
		clear_history(2'd0);
		lookup_row(PC_B, 1'b1, 1'b1, 2'd2, 3'd4, 2'd2, "b after first taken");
		update_row(PC_B, 1'b1);
		clear_history(2'd0);
		lookup_row(PC_B, 1'b1, 1'b1, 2'd2, 3'd5, 2'd3, "b after second taken");
	endtask

	task automatic apply_lookup(input int r);
		lookup = 1'b1;
		lookup_pc = pcs[row_pc[r]];
		@(negedge clk);
		while (!pred_valid) @(negedge clk);
		lookup = 1'b0;
		meta_taken = pred_taken;
		meta_hit = pred_hit;
		meta_provider = pred_provider;
		meta_ctr = pred_ctr;
		meta_u = pred_u;
		meta_u_mask = pred_u_mask;
		meta_base_ctr = pred_base_ctr;
		if (pred_taken !== exp_taken[r]) begin
			errors++;
			$display("FAILED %s: pred_taken expected %0b actual %0b",
				row_name[r], exp_taken[r], pred_taken);
		end
		if (pred_hit !== exp_hit[r]) begin
			errors++;
			$display("FAILED %s: pred_hit expected %0b actual %0b",
				row_name[r], exp_hit[r], pred_hit);
		end
		if (pred_provider !== exp_provider[r]) begin
			errors++;
			$display("FAILED %s: pred_provider expected %0d actual %0d",
				row_name[r], exp_provider[r], pred_provider);
		end
		if (exp_hit[r] && pred_ctr !== exp_ctr[r]) begin
			errors++;
			$display("FAILED %s: pred_ctr expected %0d actual %0d",
				row_name[r], exp_ctr[r], pred_ctr);
		end
		if (pred_base_ctr !== exp_base[r]) begin
			errors++;
			$display("FAILED %s: pred_base_ctr expected %0d actual %0d",
				row_name[r], exp_base[r], pred_base_ctr);
		end
		// no row has the provider disagree with the base, which keeps every u at zero
		if (exp_hit[r] && pred_u !== '0) begin
			errors++;
			$display("FAILED %s: pred_u expected 0 actual %0d", row_name[r], pred_u);
		end
		if (pred_u_mask !== '0) begin
			errors++;
			$display("FAILED %s: pred_u_mask expected 0000 actual %b",
				row_name[r], pred_u_mask);
		end
	endtask

	task automatic send_update(input int r);
		update = 1'b1;
		upd_pc = pcs[row_pc[r]];
		upd_taken = row_outcome[r];
		upd_hit = meta_hit;
		upd_provider = meta_provider;
		upd_ctr = meta_ctr;
		upd_u = meta_u;
		upd_u_mask = meta_u_mask;
		upd_pred_taken = meta_taken;
		upd_base_ctr = meta_base_ctr;
		@(negedge clk);
		update = 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		lookup = 1'b0;
		lookup_pc = '0;
		update = 1'b0;
		upd_pc = '0;
		upd_taken = 1'b0;
		upd_hit = 1'b0;
		upd_provider = '0;
		upd_ctr = '0;
		upd_u = '0;
		upd_u_mask = '0;
		upd_pred_taken = 1'b0;
		upd_base_ctr = '0;
		errors = 0;
		cycles = 0;
		n_rows = 0;
		seed = 24569;
		pick_pcs();
		build_table();
		timeout_limit = n_rows * 3 + 8 + 20;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		for (int r = 0; r < n_rows; r++) begin
			if (row_kind[r] == KIND_LOOKUP) begin
				apply_lookup(r);
			end else begin
				send_update(r);
			end
		end
		@(negedge clk);
		$display("rows: %0d, errors: %0d", n_rows, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/tage_chk.sv
`timescale 1ns/1ps
`default_nettype none

module tage_chk (
	input logic clk,
	input logic rst_n,
	input logic lookup,
	input logic pred_valid,
	input logic pred_hit,
	input tage_pkg::bank_id_t pred_provider,
	input tage_pkg::ctr_t pred_ctr,
	input tage_pkg::u_t pred_u,
	input tage_pkg::bank_mask_t pred_u_mask
);

	// one result per strobe one cycle later
	a_valid_after_lookup: assert property (@(posedge clk) disable iff (!rst_n)
		lookup |=> pred_valid)
		else $error("pred_valid missing one cycle after lookup");

	a_valid_only_after_lookup: assert property (@(posedge clk) disable iff (!rst_n)
		!lookup |=> !pred_valid)
		else $error("pred_valid high without a lookup");

	a_valid_low_in_reset: assert property (@(posedge clk)
		!rst_n |=> !pred_valid)
		else $error("pred_valid high during reset");

	// read results only move on a lookup
	a_pred_hold: assert property (@(posedge clk) disable iff (!rst_n)
		!lookup |=> $stable({pred_hit, pred_provider, pred_ctr, pred_u, pred_u_mask}))
		else $error("prediction fields changed without a lookup");

endmodule

`default_nettype wire

// File: verilog/tage_top.sv
`timescale 1ns/1ps
`default_nettype none

module tage_top (
	input  logic clk,
	input  logic rst_n,
	input  logic lookup,
	input  tage_pkg::pc_t lookup_pc,
	input  logic update,
	input  tage_pkg::pc_t upd_pc,
	input  logic upd_taken,
	input  logic upd_hit,
	input  tage_pkg::bank_id_t upd_provider,
	input  tage_pkg::ctr_t upd_ctr,
	input  tage_pkg::u_t upd_u,
	input  tage_pkg::bank_mask_t upd_u_mask,
	input  logic upd_pred_taken,
	input  tage_pkg::base_ctr_t upd_base_ctr,
	output logic pred_valid,
	output logic pred_taken,
	output logic pred_hit,
	output tage_pkg::bank_id_t pred_provider,
	output tage_pkg::ctr_t pred_ctr,
	output tage_pkg::u_t pred_u,
	output tage_pkg::bank_mask_t pred_u_mask,
	output tage_pkg::base_ctr_t pred_base_ctr
);
	import tage_pkg::*;

	idx_t fold_idx [NUM_BANKS];
	tag_t fold_tag [NUM_BANKS];
	base_idx_t base_lookup_idx;
	base_idx_t base_upd_idx;
	base_ctr_t base_ctr;

	tage_bank_if bank_bus [NUM_BANKS] ();

	tage_history u_history (
		.clk       (clk),
		.rst_n     (rst_n),
		.update    (update),
		.upd_taken (upd_taken),
		.fold_idx  (fold_idx),
		.fold_tag  (fold_tag)
	);

	tage_hash u_hash (
		.lookup_pc       (lookup_pc),
		.upd_pc          (upd_pc),
		.fold_idx        (fold_idx),
		.fold_tag        (fold_tag),
		.banks           (bank_bus),
		.base_lookup_idx (base_lookup_idx),
		.base_upd_idx    (base_upd_idx)
	);

	for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
		tage_bank u_bank (
			.clk    (clk),
			.rst_n  (rst_n),
			.lookup (lookup),
			.bus    (bank_bus[g])
		);
	end

	tage_base u_base (
		.clk             (clk),
		.rst_n           (rst_n),
		.lookup          (lookup),
		.update          (update),
		.upd_taken       (upd_taken),
		.base_lookup_idx (base_lookup_idx),
		.base_upd_idx    (base_upd_idx),
		.upd_base_ctr    (upd_base_ctr),
		.base_ctr        (base_ctr)
	);

	tage_select u_select (
		.clk            (clk),
		.rst_n          (rst_n),
		.lookup         (lookup),
		.update         (update),
		.upd_taken      (upd_taken),
		.banks          (bank_bus),
		.base_ctr       (base_ctr),
		.pred_valid     (pred_valid),
		.pred_taken     (pred_taken),
		.pred_hit       (pred_hit),
		.pred_provider  (pred_provider),
		.pred_ctr       (pred_ctr),
		.pred_u         (pred_u),
		.pred_u_mask    (pred_u_mask),
		.pred_base_ctr  (pred_base_ctr),
		.upd_hit        (upd_hit),
		.upd_provider   (upd_provider),
		.upd_ctr        (upd_ctr),
		.upd_u          (upd_u),
		.upd_u_mask     (upd_u_mask),
		.upd_pred_taken (upd_pred_taken),
		.upd_base_ctr   (upd_base_ctr)
	);

endmodule

`default_nettype wire

// File: verilog/tage_select.sv
`timescale 1ns/1ps
`default_nettype none

module tage_select (
	input  logic clk,
	input  logic rst_n,
	input  logic lookup,
	input  logic update,
	input  logic upd_taken,
	tage_bank_if.sel banks [tage_pkg::NUM_BANKS],
	input  tage_pkg::base_ctr_t base_ctr,
	output logic pred_valid,
	output logic pred_taken,
	output logic pred_hit,
	output tage_pkg::bank_id_t pred_provider,
	output tage_pkg::ctr_t pred_ctr,
	output tage_pkg::u_t pred_u,
	output tage_pkg::bank_mask_t pred_u_mask,
	output tage_pkg::base_ctr_t pred_base_ctr,
	input  logic upd_hit,
	input  tage_pkg::bank_id_t upd_provider,
	input  tage_pkg::ctr_t upd_ctr,
	input  tage_pkg::u_t upd_u,
	input  tage_pkg::bank_mask_t upd_u_mask,
	input  logic upd_pred_taken,
	input  tage_pkg::base_ctr_t upd_base_ctr
);
	import tage_pkg::*;

	bank_mask_t hit_vec;
	ctr_t ctr_arr [NUM_BANKS];
	u_t u_arr [NUM_BANKS];

	bank_mask_t wr_entry;
	bank_mask_t wr_alloc;
	bank_mask_t u_wr;
	ctr_t wr_ctr [NUM_BANKS];
	u_t u_val [NUM_BANKS];

	bank_mask_t cand;
	bank_mask_t free_mask;
	bank_id_t alloc_bank;
	logic prov_pred;
	logic alt_pred;
	logic mispred;

	function automatic ctr_t ctr_step(input ctr_t c, input logic up);
		if (up && c != '1) return c + 1'b1;
		if (!up && c != '0) return c - 1'b1;
		return c;
	endfunction

	function automatic u_t u_step(input u_t v, input logic up);
		if (up && v != '1) return v + 1'b1;
		if (!up && v != '0) return v - 1'b1;
		return v;
	endfunction

	for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
		assign hit_vec[g] = banks[g].hit;
		assign ctr_arr[g] = banks[g].ctr;
		assign u_arr[g] = banks[g].u;
		assign pred_u_mask[g] = |banks[g].u;
		assign banks[g].wr_entry = wr_entry[g];
		assign banks[g].wr_alloc = wr_alloc[g];
		assign banks[g].wr_ctr = wr_ctr[g];
		assign banks[g].u_wr = u_wr[g];
		assign banks[g].u_val = u_val[g];
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pred_valid <= 1'b0;
		end else begin
			pred_valid <= lookup;
		end
	end

	// longest history wins
	always_comb begin
		pred_provider = '0;
		for (int b = 0; b < NUM_BANKS; b++) begin
			if (hit_vec[b]) begin
				pred_provider = bank_id_t'(b);
			end
		end
	end

	assign pred_hit = |hit_vec;
	assign pred_ctr = pred_hit ? ctr_arr[pred_provider] : '0;
	assign pred_u = pred_hit ? u_arr[pred_provider] : '0;
	assign pred_taken = pred_hit ? pred_ctr[CTR_W-1] : base_ctr[BASE_CTR_W-1];
	assign pred_base_ctr = base_ctr;

	assign prov_pred = upd_ctr[CTR_W-1];
	assign alt_pred = upd_base_ctr[BASE_CTR_W-1];
	assign mispred = upd_pred_taken != upd_taken;

	// banks with longer history than the provider
	always_comb begin
		for (int b = 0; b < NUM_BANKS; b++) begin
			cand[b] = !upd_hit || (bank_id_t'(b) > upd_provider);
		end
	end

	assign free_mask = cand & ~upd_u_mask;

	always_comb begin
		alloc_bank = '0;
		for (int b = NUM_BANKS - 1; b >= 0; b--) begin
			if (free_mask[b]) begin
				alloc_bank = bank_id_t'(b);
			end
		end
	end

	always_comb begin
		wr_entry = '0;
		wr_alloc = '0;
		u_wr = '0;
		for (int b = 0; b < NUM_BANKS; b++) begin
			wr_ctr[b] = ctr_step(upd_ctr, upd_taken);
			u_val[b] = '0;
		end
		if (update) begin
			if (upd_hit) begin
				wr_entry[upd_provider] = 1'b1;
				if (prov_pred != alt_pred) begin
					u_wr[upd_provider] = 1'b1;
					u_val[upd_provider] = u_step(upd_u, prov_pred == upd_taken);
				end
			end
			if (mispred) begin
				if (|free_mask) begin
					wr_entry[alloc_bank] = 1'b1;
					wr_alloc[alloc_bank] = 1'b1;
					wr_ctr[alloc_bank] = upd_taken ? CTR_ALLOC_TAKEN : CTR_ALLOC_NOT_TAKEN;
				end else begin
					// a nonzero u counts as one step and drops to zero
					for (int b = 0; b < NUM_BANKS; b++) begin
						if (cand[b]) begin
							u_wr[b] = 1'b1;
						end
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/tage_base.sv
`timescale 1ns/1ps
`default_nettype none

module tage_base (
	input  logic clk,
	input  logic rst_n,
	input  logic lookup,
	input  logic update,
	input  logic upd_taken,
	input  tage_pkg::base_idx_t base_lookup_idx,
	input  tage_pkg::base_idx_t base_upd_idx,
	input  tage_pkg::base_ctr_t upd_base_ctr,
	output tage_pkg::base_ctr_t base_ctr
);
	import tage_pkg::*;

	base_ctr_t tbl [BASE_DEPTH];
	base_ctr_t next_ctr;

	// trained from the counter seen at prediction time
	always_comb begin
		next_ctr = upd_base_ctr;
		if (upd_taken && upd_base_ctr != '1) begin
			next_ctr = upd_base_ctr + 1'b1;
		end else if (!upd_taken && upd_base_ctr != '0) begin
			next_ctr = upd_base_ctr - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < BASE_DEPTH; i++) begin
				tbl[i] <= BASE_CTR_RESET;
			end
			base_ctr <= BASE_CTR_RESET;
		end else begin
			if (update) begin
				tbl[base_upd_idx] <= next_ctr;
			end
			if (lookup) begin
				base_ctr <= tbl[base_lookup_idx];
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/tage_bank.sv
`timescale 1ns/1ps
`default_nettype none

module tage_bank (
	input  logic clk,
	input  logic rst_n,
	input  logic lookup,
	tage_bank_if.bank bus
);
	import tage_pkg::*;

	logic [BANK_DEPTH-1:0] valid;
	tag_t tag_tbl [BANK_DEPTH];
	ctr_t ctr_tbl [BANK_DEPTH];
	u_t u_tbl [BANK_DEPTH];

	logic u_we;
	u_t u_wdata;

	// allocation also clears usefulness
	assign u_we = bus.u_wr | bus.wr_alloc;
	assign u_wdata = bus.wr_alloc ? '0 : bus.u_val;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid <= '0;
			for (int i = 0; i < BANK_DEPTH; i++) begin
				u_tbl[i] <= '0;
			end
		end else begin
			if (bus.wr_entry) begin
				valid[bus.upd_idx] <= 1'b1;
			end
			if (u_we) begin
				u_tbl[bus.upd_idx] <= u_wdata;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (bus.wr_entry) begin
			tag_tbl[bus.upd_idx] <= bus.upd_tag;
			ctr_tbl[bus.upd_idx] <= bus.wr_ctr;
		end
	end

	// registered read, held until the next lookup
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bus.hit <= 1'b0;
			bus.u <= '0;
		end else if (lookup) begin
			bus.hit <= valid[bus.lookup_idx] &&
				(tag_tbl[bus.lookup_idx] == bus.lookup_tag);
			bus.u <= u_tbl[bus.lookup_idx];
		end
	end

	always_ff @(posedge clk) begin
		if (lookup) begin
			bus.ctr <= ctr_tbl[bus.lookup_idx];
		end
	end

endmodule

`default_nettype wire

// File: verilog/tage_hash.sv
`timescale 1ns/1ps
`default_nettype none

module tage_hash (
	input  tage_pkg::pc_t lookup_pc,
	input  tage_pkg::pc_t upd_pc,
	input  tage_pkg::idx_t fold_idx [tage_pkg::NUM_BANKS],
	input  tage_pkg::tag_t fold_tag [tage_pkg::NUM_BANKS],
	tage_bank_if.hash banks [tage_pkg::NUM_BANKS],
	output tage_pkg::base_idx_t base_lookup_idx,
	output tage_pkg::base_idx_t base_upd_idx
);
	import tage_pkg::*;

	function automatic idx_t bank_index(input pc_t pc, input idx_t fold);
		idx_t lo;
		idx_t hi;
		lo = pc[IDX_W+1:2];
		hi = pc[2*IDX_W+1:IDX_W+2];
		return lo ^ hi ^ fold;
	endfunction

	function automatic tag_t bank_tag(input pc_t pc, input tag_t fold);
		tag_t rot;
		rot = {fold[TAG_W-2:0], fold[TAG_W-1]};
		return pc[TAG_W+1:2] ^ rot;
	endfunction

	assign base_lookup_idx = lookup_pc[BASE_IDX_W+1:2];
	assign base_upd_idx = upd_pc[BASE_IDX_W+1:2];

	// update side sees the history before its own shift
	for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
		assign banks[g].lookup_idx = bank_index(lookup_pc, fold_idx[g]);
		assign banks[g].lookup_tag = bank_tag(lookup_pc, fold_tag[g]);
		assign banks[g].upd_idx = bank_index(upd_pc, fold_idx[g]);
		assign banks[g].upd_tag = bank_tag(upd_pc, fold_tag[g]);
	end

endmodule

`default_nettype wire

// File: verilog/tage_history.sv
`timescale 1ns/1ps
`default_nettype none

module tage_history (
	input  logic clk,
	input  logic rst_n,
	input  logic update,
	input  logic upd_taken,
	output tage_pkg::idx_t fold_idx [tage_pkg::NUM_BANKS],
	output tage_pkg::tag_t fold_tag [tage_pkg::NUM_BANKS]
);
	import tage_pkg::*;

	ghist_t ghist;

	// newest outcome at bit 0
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ghist <= '0;
		end else if (update) begin
			ghist <= {ghist[GHIST_W-2:0], upd_taken};
		end
	end

	// xor of consecutive chunks over the newest HIST_LEN bits
	always_comb begin
		for (int b = 0; b < NUM_BANKS; b++) begin
			fold_idx[b] = '0;
			fold_tag[b] = '0;
			for (int i = 0; i < GHIST_W; i++) begin
				if (i < HIST_LEN[b]) begin
					fold_idx[b][i % IDX_W] = fold_idx[b][i % IDX_W] ^ ghist[i];
					fold_tag[b][i % TAG_W] = fold_tag[b][i % TAG_W] ^ ghist[i];
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/tage_bank_if.sv
`timescale 1ns/1ps
`default_nettype none

interface tage_bank_if;
	import tage_pkg::*;

	// from the hash unit
	idx_t lookup_idx;
	tag_t lookup_tag;
	idx_t upd_idx;
	tag_t upd_tag;

	// from the selector
	logic wr_entry;
	ctr_t wr_ctr;
	logic wr_alloc;
	logic u_wr;
	u_t u_val;

	// registered read results
	logic hit;
	ctr_t ctr;
	u_t u;

	modport hash (output lookup_idx, lookup_tag, upd_idx, upd_tag);

	modport sel (
		output wr_entry, wr_ctr, wr_alloc, u_wr, u_val,
		input hit, ctr, u
	);

	modport bank (
		input lookup_idx, lookup_tag, upd_idx, upd_tag,
		input wr_entry, wr_ctr, wr_alloc, u_wr, u_val,
		output hit, ctr, u
	);

endinterface

`default_nettype wire

// File: verilog/tage_pkg.sv
`default_nettype none

package tage_pkg;

	localparam int NUM_BANKS = 4;
	localparam int IDX_W = 6;
	localparam int TAG_W = 8;
	localparam int CTR_W = 3;
	localparam int U_W = 2;
	localparam int BASE_IDX_W = 8;
	localparam int BASE_CTR_W = 2;
	localparam int GHIST_W = 32;
	localparam int PC_W = 32;

	localparam int BANK_DEPTH = 2 ** IDX_W;
	localparam int BASE_DEPTH = 2 ** BASE_IDX_W;

	// history length per bank, shortest first
	localparam int HIST_LEN [NUM_BANKS] = '{4, 8, 16, 32};

	typedef logic [PC_W-1:0] pc_t;
	typedef logic [IDX_W-1:0] idx_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [CTR_W-1:0] ctr_t;
	typedef logic [U_W-1:0] u_t;
	typedef logic [BASE_IDX_W-1:0] base_idx_t;
	typedef logic [BASE_CTR_W-1:0] base_ctr_t;
	typedef logic [1:0] bank_id_t;
	typedef logic [GHIST_W-1:0] ghist_t;
	typedef logic [NUM_BANKS-1:0] bank_mask_t;

	// weak taken / weak not taken for a fresh entry
	localparam ctr_t CTR_ALLOC_TAKEN = ctr_t'(4);
	localparam ctr_t CTR_ALLOC_NOT_TAKEN = ctr_t'(3);

	// weakly not taken
	localparam base_ctr_t BASE_CTR_RESET = base_ctr_t'(1);

endpackage

`default_nettype wire
